//--- design/isa_pkg.sv
`default_nettype none

package isa_pkg;

    localparam int NUM_REGS = 8;
    localparam int WORD_MSB = 15;

    typedef logic [WORD_MSB:0] word_t;
    typedef logic [2:0]        reg_idx_t;
    typedef logic [6:0]        opcode_t;
    typedef logic [3:0]        alu_fs_t;
    typedef logic [6:0]        ctrl_flags_t;
    typedef logic [3:0]        alu_flags_t;   // {Z, N, C, V}
    typedef logic [5:0]        const_t;

    localparam int DR_LSB    = 13;
    localparam int SA_LSB    = 10;
    localparam int SB_LSB    = 7;
    localparam int KONST_LSB = 7;             // Overlaps SA and SB

    localparam opcode_t OP_ADD  = 7'd0;
    localparam opcode_t OP_SUB  = 7'd1;
    localparam opcode_t OP_AND  = 7'd2;
    localparam opcode_t OP_OR   = 7'd3;
    localparam opcode_t OP_XOR  = 7'd4;
    localparam opcode_t OP_NOT  = 7'd5;
    localparam opcode_t OP_LD   = 7'd6;
    localparam opcode_t OP_ST   = 7'd7;
    localparam opcode_t OP_HALT = 7'd8;
    localparam opcode_t OP_LDI  = 7'd9;

    localparam alu_fs_t FS_PASS = 4'b0000;
    localparam alu_fs_t FS_ADD  = 4'b0001;
    localparam alu_fs_t FS_SUB  = 4'b0010;
    localparam alu_fs_t FS_AND  = 4'b0100;
    localparam alu_fs_t FS_OR   = 4'b0101;
    localparam alu_fs_t FS_XOR  = 4'b0110;
    localparam alu_fs_t FS_NOT  = 4'b0111;

    localparam int CF_REG_WE = 0;
    localparam int CF_MEM_WE = 1;
    localparam int CF_MEM_RD = 2;
    localparam int CF_CONST  = 3;
    localparam int CF_HALT   = 4;

    localparam int AF_V = 0;
    localparam int AF_C = 1;
    localparam int AF_N = 2;
    localparam int AF_Z = 3;

endpackage

`default_nettype wire

//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int MEM_DEPTH = 256;
    localparam int MEM_AW    = $clog2(MEM_DEPTH);

    typedef logic [MEM_AW-1:0] mem_addr_t;
    typedef logic [15:0]       mem_data_t;   // Same width as a register

endpackage

`default_nettype wire

//--- design/mem_if.sv
`default_nettype none

interface mem_if;
    import mem_pkg::*;

    logic      req;
    logic      we;
    mem_addr_t addr;
    mem_data_t wdata;
    logic      gnt;      // Same cycle as req
    mem_data_t rdata;
    logic      rvalid;   // One cycle after gnt

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

`default_nettype wire

//--- design/decode_if.sv
`default_nettype none

interface decode_if;
    import isa_pkg::*;

    reg_idx_t    dr;
    reg_idx_t    sa;
    reg_idx_t    sb;
    alu_fs_t     fs;
    ctrl_flags_t flags;
    const_t      konst;
    logic        valid;   // Fields stay until the next strobe

    modport source (output dr, sa, sb, fs, flags, konst, valid);
    modport sink   (input  dr, sa, sb, fs, flags, konst, valid);

endinterface

`default_nettype wire

//--- design/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
    input  logic   CLK,
    input  logic   RST,
    mem_if.arbiter core,
    mem_if.arbiter host
);
    import mem_pkg::*;

    mem_data_t mem [MEM_DEPTH];
    logic      acc_en;
    logic      acc_we;
    mem_addr_t acc_addr;
    mem_data_t acc_wdata;
    mem_data_t core_rdata_q;
    mem_data_t host_rdata_q;
    logic      core_rvalid_q;
    logic      host_rvalid_q;

    assign core.gnt = core.req;               // Core has fixed priority
    assign host.gnt = host.req & ~core.req;

    assign acc_en    = core.gnt | host.gnt;
    assign acc_we    = core.req ? core.we    : host.we;
    assign acc_addr  = core.req ? core.addr  : host.addr;
    assign acc_wdata = core.req ? core.wdata : host.wdata;

    always_ff @(posedge CLK) begin
        if (acc_en && acc_we) begin
            mem[acc_addr] <= acc_wdata;
        end
        if (core.gnt && !core.we) begin
            core_rdata_q <= mem[acc_addr];
        end
        if (host.gnt && !host.we) begin
            host_rdata_q <= mem[acc_addr];   // Held until the next host read
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            core_rvalid_q <= 1'b0;
            host_rvalid_q <= 1'b0;
        end else begin
            core_rvalid_q <= core.gnt;
            host_rvalid_q <= host.gnt;
        end
    end

    assign core.rdata  = core_rdata_q;
    assign core.rvalid = core_rvalid_q;
    assign host.rdata  = host_rdata_q;
    assign host.rvalid = host_rvalid_q;

endmodule

`default_nettype wire

//--- design/control_unit.sv
`default_nettype none

module control_unit (
    input  logic           CLK,
    input  logic           RST,
    input  isa_pkg::word_t instr,
    input  logic           instr_valid,
    decode_if.source       dec
);
    import isa_pkg::*;

    opcode_t     opcode;
    alu_fs_t     fs_n;
    ctrl_flags_t flags_n;

    assign opcode = instr[$bits(opcode_t)-1:0];

    always_comb begin
        fs_n    = FS_PASS;
        flags_n = '0;
        case (opcode)
            OP_ADD:  fs_n = FS_ADD;
            OP_SUB:  fs_n = FS_SUB;
            OP_AND:  fs_n = FS_AND;
            OP_OR:   fs_n = FS_OR;
            OP_XOR:  fs_n = FS_XOR;
            OP_NOT:  fs_n = FS_NOT;
            default: fs_n = FS_PASS;
        endcase
        case (opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOT: begin
                flags_n[CF_REG_WE] = 1'b1;
            end
            OP_LD: begin
                flags_n[CF_REG_WE] = 1'b1;
                flags_n[CF_MEM_RD] = 1'b1;
            end
            OP_ST:   flags_n[CF_MEM_WE] = 1'b1;
            OP_LDI: begin
                flags_n[CF_REG_WE] = 1'b1;
                flags_n[CF_CONST]  = 1'b1;
            end
            OP_HALT: flags_n[CF_HALT] = 1'b1;
            default: flags_n = '0;      // Unknown opcode still commits
        endcase
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            dec.valid <= 1'b0;
            dec.dr    <= '0;
            dec.sa    <= '0;
            dec.sb    <= '0;
            dec.fs    <= FS_PASS;
            dec.flags <= '0;
            dec.konst <= '0;
        end else begin
            dec.valid <= instr_valid;
            if (instr_valid) begin
                dec.dr    <= instr[DR_LSB +: $bits(reg_idx_t)];
                dec.sa    <= instr[SA_LSB +: $bits(reg_idx_t)];
                dec.sb    <= instr[SB_LSB +: $bits(reg_idx_t)];
                dec.konst <= instr[KONST_LSB +: $bits(const_t)];
                dec.fs    <= fs_n;
                dec.flags <= flags_n;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/datapath.sv
`default_nettype none

module datapath (
    input  logic                CLK,
    input  logic                RST,
    decode_if.sink              dec,
    input  logic                wb_en,
    input  mem_pkg::mem_data_t  mem_rdata,
    output isa_pkg::word_t      a_val,
    output isa_pkg::word_t      b_val,
    output isa_pkg::word_t      wb_data,
    output isa_pkg::alu_flags_t flags
);
    import isa_pkg::*;

    word_t      regs [NUM_REGS];
    word_t      alu_res;
    logic       carry;
    logic       ovf;
    alu_flags_t alu_flags;
    alu_flags_t flags_q;
    logic       flags_we;

    assign a_val = regs[dec.sa];
    assign b_val = regs[dec.sb];

    always_comb begin
        carry = 1'b0;
        ovf   = 1'b0;
        case (dec.fs)
            FS_ADD: begin
                {carry, alu_res} = {1'b0, a_val} + {1'b0, b_val};
                ovf = (a_val[WORD_MSB] == b_val[WORD_MSB]) &&
                      (alu_res[WORD_MSB] != a_val[WORD_MSB]);
            end
            FS_SUB: begin
                {carry, alu_res} = {1'b0, a_val} + {1'b0, ~b_val} + 17'd1;
                ovf = (a_val[WORD_MSB] != b_val[WORD_MSB]) &&
                      (alu_res[WORD_MSB] != a_val[WORD_MSB]);
            end
            FS_AND:  alu_res = a_val & b_val;
            FS_OR:   alu_res = a_val | b_val;
            FS_XOR:  alu_res = a_val ^ b_val;
            FS_NOT:  alu_res = ~a_val;
            default: alu_res = a_val;
        endcase
    end

    always_comb begin
        alu_flags       = '0;
        alu_flags[AF_Z] = (alu_res == '0);
        alu_flags[AF_N] = alu_res[WORD_MSB];
        alu_flags[AF_C] = carry;
        alu_flags[AF_V] = ovf;
    end

    // Only ALU results update the flags
    assign flags_we = wb_en & ~dec.flags[CF_CONST] & ~dec.flags[CF_MEM_RD];
    assign flags    = flags_we ? alu_flags : flags_q;

    always_comb begin
        if (dec.flags[CF_CONST]) begin
            wb_data = word_t'(dec.konst);    // Zero-extended
        end else if (dec.flags[CF_MEM_RD]) begin
            wb_data = word_t'(mem_rdata);
        end else begin
            wb_data = alu_res;
        end
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            flags_q <= '0;
        end else if (wb_en) begin
            regs[dec.dr] <= wb_data;
            flags_q      <= flags;
        end
    end

endmodule

`default_nettype wire

//--- design/sequencer.sv
`default_nettype none

module sequencer (
    input  logic           CLK,
    input  logic           RST,
    input  logic           run,
    mem_if.requester       mem,
    decode_if.sink         dec,
    output isa_pkg::word_t instr,
    output logic           instr_valid,
    input  isa_pkg::word_t a_val,
    input  isa_pkg::word_t b_val,
    output logic           wb_en,
    output logic           commit,
    output logic           halted
);
    import isa_pkg::*;
    import mem_pkg::*;

    typedef enum logic [2:0] {IDLE, FETCH, DECODE, EXEC, MEM, HALT} state_t;

    state_t    state;
    state_t    state_n;
    state_t    after_commit;
    mem_addr_t pc;
    logic      rd_issued;
    logic      is_ld;
    logic      is_st;

    assign is_ld        = dec.flags[CF_MEM_RD];
    assign is_st        = dec.flags[CF_MEM_WE];
    assign after_commit = run ? FETCH : IDLE;
    assign instr        = mem.rdata;
    assign instr_valid  = (state == DECODE) && mem.rvalid;
    assign halted       = (state == HALT);

    always_comb begin
        state_n   = state;
        mem.req   = 1'b0;
        mem.we    = 1'b0;
        mem.addr  = pc;
        mem.wdata = b_val;
        commit    = 1'b0;
        wb_en     = 1'b0;
        case (state)
            IDLE:   if (run) state_n = FETCH;
            FETCH: begin
                mem.req = 1'b1;
                if (mem.gnt) state_n = DECODE;
            end
            DECODE: if (dec.valid) state_n = EXEC;
            EXEC: begin
                if (is_st) begin
                    mem.req  = 1'b1;
                    mem.we   = 1'b1;
                    mem.addr = a_val[MEM_AW-1:0];
                    if (mem.gnt) state_n = MEM;
                end else if (is_ld) begin
                    state_n = MEM;                     // Read goes out next cycle
                end else begin
                    commit  = 1'b1;
                    wb_en   = dec.flags[CF_REG_WE];
                    state_n = dec.flags[CF_HALT] ? HALT : after_commit;
                end
            end
            MEM: begin
                if (is_ld && !rd_issued) begin
                    mem.req  = 1'b1;
                    mem.addr = a_val[MEM_AW-1:0];
                end else if (mem.rvalid) begin
                    commit  = 1'b1;                    // Store ack or load data
                    wb_en   = dec.flags[CF_REG_WE];
                    state_n = after_commit;
                end
            end
            HALT:    state_n = HALT;                   // Left only by reset
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state     <= IDLE;
            pc        <= '0;
            rd_issued <= 1'b0;
        end else begin
            state <= state_n;
            if (state == FETCH && mem.gnt) begin
                pc <= pc + mem_addr_t'(1);
            end
            if (commit) begin
                rd_issued <= 1'b0;
            end else if (state == MEM && is_ld && mem.gnt) begin
                rd_issued <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/computer_top.sv
`default_nettype none

module computer_top (
    input  logic                CLK,
    input  logic                RST,
    input  logic                run,
    input  logic                host_req,
    input  logic                host_we,
    input  mem_pkg::mem_addr_t  host_addr,
    input  mem_pkg::mem_data_t  host_wdata,
    output logic                host_ack,
    output mem_pkg::mem_data_t  host_rdata,
    output logic                commit,
    output isa_pkg::reg_idx_t   commit_dr,
    output logic                commit_we,
    output isa_pkg::word_t      commit_data,
    output isa_pkg::alu_flags_t commit_flags,
    output logic                halted
);
    import isa_pkg::*;

    mem_if    core_bus ();
    mem_if    host_bus ();
    decode_if dec_bus ();

    word_t instr;
    logic  instr_valid;
    word_t a_val;
    word_t b_val;
    logic  wb_en;

    assign host_bus.req   = host_req;
    assign host_bus.we    = host_we;
    assign host_bus.addr  = host_addr;
    assign host_bus.wdata = host_wdata;
    assign host_ack       = host_bus.rvalid;
    assign host_rdata     = host_bus.rdata;

    assign commit_dr = dec_bus.dr;
    assign commit_we = wb_en;          // Only high in a commit cycle

    mem_arbiter u_arbiter (
        .CLK  (CLK),
        .RST  (RST),
        .core (core_bus.arbiter),
        .host (host_bus.arbiter)
    );

    control_unit u_control (
        .CLK         (CLK),
        .RST         (RST),
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec_bus.source)
    );

    datapath u_datapath (
        .CLK       (CLK),
        .RST       (RST),
        .dec       (dec_bus.sink),
        .wb_en     (wb_en),
        .mem_rdata (core_bus.rdata),
        .a_val     (a_val),
        .b_val     (b_val),
        .wb_data   (commit_data),
        .flags     (commit_flags)
    );

    sequencer u_sequencer (
        .CLK         (CLK),
        .RST         (RST),
        .run         (run),
        .mem         (core_bus.requester),
        .dec         (dec_bus.sink),
        .instr       (instr),
        .instr_valid (instr_valid),
        .a_val       (a_val),
        .b_val       (b_val),
        .wb_en       (wb_en),
        .commit      (commit),
        .halted      (halted)
    );

endmodule

`default_nettype wire

//--- tb/computer_checker.sv
`default_nettype none

module computer_checker (
    input logic CLK,
    input logic RST,
    input logic core_gnt,
    input logic core_rvalid,
    input logic host_req,
    input logic host_gnt,
    input logic host_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;

    a_single_grant: assert property (@(posedge CLK) disable iff (RST)
        !(core_gnt && host_gnt))
        else $error("memory granted to core and host in the same cycle");

    a_core_rvalid_after_gnt: assert property (@(posedge CLK) disable iff (RST)
        core_gnt |=> core_rvalid)
        else $error("core rvalid missing one cycle after its grant");

    a_host_rvalid_after_gnt: assert property (@(posedge CLK) disable iff (RST)
        host_gnt |=> host_rvalid)
        else $error("host rvalid missing one cycle after its grant");

    a_core_rvalid_needs_gnt: assert property (@(posedge CLK) disable iff (RST)
        core_rvalid |-> $past(core_gnt))
        else $error("core rvalid without a grant in the cycle before");

    a_host_rvalid_needs_gnt: assert property (@(posedge CLK) disable iff (RST)
        host_rvalid |-> $past(host_gnt))
        else $error("host rvalid without a grant in the cycle before");

    // Host may only drop its request once the access is acknowledged
    a_host_req_held: assert property (@(posedge CLK) disable iff (RST)
        $fell(host_req) |-> host_rvalid)
        else $error("host request dropped before its acknowledge");

endmodule

bind mem_arbiter computer_checker u_checker (
    .CLK         (CLK),
    .RST         (RST),
    .core_gnt    (core.gnt),
    .core_rvalid (core.rvalid),
    .host_req    (host.req),
    .host_gnt    (host.gnt),
    .host_rvalid (host.rvalid)
);

`default_nettype wire

//--- tb/computer_tb.sv
`default_nettype none

module computer_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;
    import mem_pkg::*;

    typedef struct packed {
        reg_idx_t   dr;
        logic       we;
        word_t      data;
        alu_flags_t flags;
    } commit_t;

    localparam int DATA_BASE = 56;                 // Above the longest program
    localparam int TIMEOUT_CYCLES =
        (10 * 0  + 4 * 32 + 200) +
        (10 * 21 + 4 * 21 + 200) +
        (10 * 21 + 4 * 25 + 200) +
        (10 * 49 + 4 * 73 + 200) +
        (10 * 9  + 4 * 11 + 200);

    logic        CLK;
    logic        RST;
    logic        run;
    logic        host_req;
    logic        host_we;
    mem_addr_t   host_addr;
    mem_data_t   host_wdata;
    logic        host_ack;
    mem_data_t   host_rdata;
    logic        commit;
    reg_idx_t    commit_dr;
    logic        commit_we;
    word_t       commit_data;
    alu_flags_t  commit_flags;
    logic        halted;

    word_t       mregs [NUM_REGS];
    mem_data_t   mmem [MEM_DEPTH];
    alu_flags_t  mflags;
    word_t       prog [$];
    word_t       pending_q [$];
    mem_addr_t   addr_q [$];
    logic [31:0] rng_state = 32'd26;
    string       test_name = "none";
    int          errors;
    int          checks;
    int          commits;
    int          base_errors;
    int          tests_run;
    int          tests_failed;
    int          cycles;

    computer_top DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    function automatic word_t make_instr(input opcode_t op, input reg_idx_t dr,
                                         input reg_idx_t sa, input reg_idx_t sb);
        return {dr, sa, sb, op};
    endfunction

    function automatic word_t make_ldi(input reg_idx_t dr, input const_t k);
        return {dr, k, OP_LDI};
    endfunction

    // Executes one instruction on the model and returns what the commit must show
    function automatic commit_t exec_ref(input word_t iw);
        commit_t     e;
        opcode_t     op;
        word_t       a;
        word_t       b;
        logic [16:0] sum;
        int          sres;
        logic        ovf;
        logic        alu;
        op      = iw[6:0];
        a       = mregs[iw[12:10]];
        b       = mregs[iw[9:7]];
        e.dr    = iw[15:13];
        e.we    = 1'b1;
        e.data  = '0;
        sum     = '0;
        sres    = 0;
        alu     = 1'b1;
        case (op)
            OP_ADD: begin
                sum  = {1'b0, a} + {1'b0, b};
                sres = $signed(a) + $signed(b);
            end
            OP_SUB: begin
                sum  = {1'b0, a} + {1'b0, ~b} + 17'd1;   // Carry means no borrow
                sres = $signed(a) - $signed(b);
            end
            OP_AND: sum = {1'b0, a & b};
            OP_OR:  sum = {1'b0, a | b};
            OP_XOR: sum = {1'b0, a ^ b};
            OP_NOT: sum = {1'b0, ~a};
            default: alu = 1'b0;
        endcase
        ovf = (sres > 32767) || (sres < -32768);        // Outside the signed 16-bit range
        case (op)
            OP_LD:  e.data = mmem[a[7:0]];
            OP_ST: begin
                mmem[a[7:0]] = b;
                e.we = 1'b0;
            end
            OP_LDI: e.data = {10'd0, iw[12:7]};
            default: if (!alu) e.we = 1'b0;           // HALT and unknown opcodes
        endcase
        if (alu) begin
            e.data = sum[15:0];
            mflags = {sum[15:0] == 16'd0, sum[15], sum[16], ovf};
        end
        if (e.we) mregs[e.dr] = e.data;
        e.flags = mflags;
        return e;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    always @(negedge CLK) begin
        commit_t exp;
        if (commit) begin
            commits++;
            if (pending_q.size() == 0) begin
                errors++;
                $display("%s: commit seen with no instruction left to execute", test_name);
            end else begin
                exp = exec_ref(pending_q.pop_front());
                check_value("commit_dr", exp.dr, commit_dr);
                check_value("commit_we", exp.we, commit_we);
                if (exp.we) check_value("commit_data", exp.data, commit_data);
                check_value("commit_flags", exp.flags, commit_flags);
            end
        end
    end

    task automatic apply_reset();
        @(negedge CLK);
        RST      = 1'b1;
        run      = 1'b0;
        host_req = 1'b0;
        host_we  = 1'b0;
        repeat (4) @(negedge CLK);
        RST = 1'b0;
        foreach (mregs[i]) mregs[i] = '0;
        mflags = '0;
    endtask

    task automatic host_write(input mem_addr_t addr, input mem_data_t data);
        @(negedge CLK);
        host_req   = 1'b1;
        host_we    = 1'b1;
        host_addr  = addr;
        host_wdata = data;
        do @(negedge CLK); while (!host_ack);
        host_req = 1'b0;
        host_we  = 1'b0;
        mmem[addr] = data;
    endtask

    task automatic host_read(input mem_addr_t addr, output mem_data_t data);
        @(negedge CLK);
        host_req  = 1'b1;
        host_we   = 1'b0;
        host_addr = addr;
        do @(negedge CLK); while (!host_ack);
        host_req = 1'b0;
        data     = host_rdata;
    endtask

    task automatic add_instr(input word_t w, input logic executes);
        prog.push_back(w);
        if (executes) pending_q.push_back(w);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        base_errors = errors;
        commits     = 0;
        prog.delete();
        pending_q.delete();
    endtask

    task automatic start_program();
        apply_reset();
        for (int i = 0; i < prog.size(); i++) host_write(mem_addr_t'(i), prog[i]);
        @(negedge CLK);
        run = 1'b1;
    endtask

    task automatic wait_halt();
        while (!halted) @(negedge CLK);
    endtask

    task automatic end_test();
        if (pending_q.size() != 0) begin
            errors++;
            $display("%s: %0d instructions never committed", test_name, pending_q.size());
        end
        tests_run++;
        if (errors != base_errors) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", test_name, errors - base_errors);
        end else begin
            $display("test %s: ok, %0d commits", test_name, commits);
        end
    endtask

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        mem_addr_t addr;
        mem_data_t rd;
        RST        = 1'b1;
        run        = 1'b0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;

        start_test("reset_and_host");
        apply_reset();
        check_value("commit", 0, commit);
        check_value("host_ack", 0, host_ack);
        check_value("halted", 0, halted);
        for (int i = 0; i < 16; i++) begin
            addr = mem_addr_t'(next_random());
            addr_q.push_back(addr);
            host_write(addr, next_random());
        end
        foreach (addr_q[i]) begin
            host_read(addr_q[i], rd);
            check_value("host_rdata", mmem[addr_q[i]], rd);
        end
        end_test();

        start_test("alu_and_ldi");
        for (int r = 0; r < NUM_REGS; r++) begin
            add_instr(make_ldi(reg_idx_t'(r), const_t'(next_random())), 1);
        end
        for (int k = 0; k < 2; k++) begin
            for (int op = OP_ADD; op <= OP_NOT; op++) begin
                add_instr(make_instr(opcode_t'(op), reg_idx_t'(next_random()),
                                     reg_idx_t'(next_random()), reg_idx_t'(next_random())), 1);
            end
        end
        add_instr(make_instr(OP_HALT, 0, 0, 0), 1);
        start_program();
        wait_halt();
        end_test();

        start_test("load_and_store");
        for (int i = 0; i < 4; i++) begin
            add_instr(make_ldi(1, const_t'(DATA_BASE + i)), 1);
            add_instr(make_ldi(2, const_t'(next_random())), 1);
            add_instr(make_instr(OP_ST, 0, 1, 2), 1);
        end
        for (int i = 0; i < 4; i++) begin
            add_instr(make_ldi(1, const_t'(DATA_BASE + i)), 1);
            add_instr(make_instr(OP_LD, reg_idx_t'(3 + i), 1, 0), 1);
        end
        add_instr(make_instr(OP_HALT, 0, 0, 0), 1);
        start_program();
        wait_halt();
        for (int i = 0; i < 4; i++) begin
            host_read(mem_addr_t'(DATA_BASE + i), rd);
            check_value("host_rdata", mmem[DATA_BASE + i], rd);
        end
        end_test();

        start_test("host_contention");
        for (int i = 0; i < 8; i++) begin
            add_instr(make_ldi(1, const_t'(DATA_BASE + i)), 1);
            add_instr(make_ldi(2, const_t'(next_random())), 1);
            add_instr(make_instr(OP_ST, 0, 1, 2), 1);
        end
        for (int i = 0; i < 8; i++) begin
            add_instr(make_ldi(1, const_t'(DATA_BASE + i)), 1);
            add_instr(make_instr(OP_LD, 3, 1, 0), 1);
            add_instr(make_instr(OP_ADD, 4, 4, 3), 1);
        end
        add_instr(make_instr(OP_HALT, 0, 0, 0), 1);
        start_program();
        for (int i = 0; i < 12; i++) begin
            addr = mem_addr_t'(next_random()) | 8'h80;   // Upper half, away from the core
            host_write(addr, next_random());
            host_read(addr, rd);
            check_value("host_rdata", mmem[addr], rd);
        end
        wait_halt();
        end_test();

        start_test("halt_and_unknown");
        add_instr(make_ldi(1, const_t'(next_random())), 1);
        add_instr(make_ldi(2, const_t'(next_random())), 1);
        add_instr(make_instr(opcode_t'(10 + next_random() % 118), 1, 2, 1), 1);
        add_instr(make_instr(OP_ADD, 3, 1, 2), 1);
        add_instr(make_instr(opcode_t'(10 + next_random() % 118), 2, 1, 1), 1);
        add_instr(make_instr(OP_SUB, 4, 1, 2), 1);
        add_instr(make_instr(opcode_t'(10 + next_random() % 118), 3, 4, 2), 1);
        add_instr(make_instr(OP_OR, 5, 3, 4), 1);
        add_instr(make_instr(OP_HALT, 0, 0, 0), 1);
        add_instr(make_ldi(6, 6'd1), 0);                 // Must never run
        add_instr(make_instr(OP_ADD, 7, 1, 2), 0);
        start_program();
        wait_halt();
        commits = 0;
        repeat (50) @(negedge CLK);
        check_value("commits after halt", 0, commits);
        check_value("halted", 1, halted);
        end_test();

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
design/isa_pkg.sv
design/mem_pkg.sv
design/mem_if.sv
design/decode_if.sv
design/mem_arbiter.sv
design/control_unit.sv
design/datapath.sv
design/sequencer.sv
design/computer_top.sv
tb/computer_checker.sv
tb/computer_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run into sim.log, decide on the log contents
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module computer_tb -o computer_sim \
    && ./obj_dir/computer_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
